/* Bender.yml */
package:
  name: processor

sources:
  - cpu_isa_pkg.sv
  - cpu_pipe_pkg.sv
  - fetch_stage.sv
  - register_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_writeback.sv
  - processor.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_processor.sv

/* cpu_isa_pkg.sv */
// ISA word types, opcode and ALU encodings, special registers and instruction field functions
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;

    // Opcode in bits 31 to 27
    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_jal   = 5'd3,
        op_jr    = 5'd4,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_t;

    // R-type ALU code in bits 6 to 2
    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    // Return address register written by jal
    localparam reg_addr_t link_reg = 5'd31;

    // add r0, r0, r0
    localparam instr_t nop_instr = '0;

    function automatic opcode_t get_op(instr_t instr);
        return opcode_t'(instr[31:27]);
    endfunction

    function automatic reg_addr_t get_rd(instr_t instr);
        return instr[26:22];
    endfunction

    function automatic reg_addr_t get_rs(instr_t instr);
        return instr[21:17];
    endfunction

    function automatic reg_addr_t get_rt(instr_t instr);
        return instr[16:12];
    endfunction

    function automatic shamt_t get_shamt(instr_t instr);
        return instr[11:7];
    endfunction

    function automatic alu_op_t get_alu_op(instr_t instr);
        return alu_op_t'(instr[6:2]);
    endfunction

    // 17-bit immediate sign-extended to a word
    function automatic word_t get_imm(instr_t instr);
        return {{15{instr[16]}}, instr[16:0]};
    endfunction

    // 27-bit jump target zero-extended to a word
    function automatic word_t get_target(instr_t instr);
        return {5'b0, instr[26:0]};
    endfunction

    // jal links into r31 and every other writer uses rd
    function automatic reg_addr_t dest_reg(instr_t instr);
        return (get_op(instr) == op_jal) ? link_reg : get_rd(instr);
    endfunction

endpackage

/* cpu_pipe_pkg.sv */
// Writeback source and forwarding select encodings with the operand forwarding functions
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic {
        wb_result = 1'b0,
        wb_load   = 1'b1
    } wb_src_t;

    typedef enum logic [1:0] {
        fwd_reg = 2'd0,
        fwd_mem = 2'd1,
        fwd_wb  = 2'd2
    } fwd_sel_t;

    // The memory-stage result is younger and wins over writeback
    function automatic fwd_sel_t fwd_select(
        reg_addr_t src,
        logic      mem_we,
        reg_addr_t mem_dest,
        logic      wb_we,
        reg_addr_t wb_dest
    );
        if (mem_we && mem_dest == src) begin
            return fwd_mem;
        end
        if (wb_we && wb_dest == src) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

/* decode_stage.sv */
// Control decode, hazard stalls, branch and jump resolution and the D/X register
`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  instr_t    fd_instr,
    input  word_t     fd_pc_next,
    output reg_addr_t rd_addr_a,
    output reg_addr_t rd_addr_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    input  instr_t    xm_instr,
    input  word_t     xm_result,
    input  logic      xm_reg_we,
    output logic      stall,
    output logic      redirect,
    output word_t     redirect_pc,
    output instr_t    dx_instr,
    output word_t     dx_pc_next,
    output word_t     dx_a,
    output word_t     dx_b,
    output logic      dx_reg_we,
    output logic      dx_mem_we,
    output logic      dx_use_imm,
    output wb_src_t   dx_wb_src
);

    opcode_t   op;
    logic      is_rtype;
    logic      is_lw;
    logic      is_sw;
    logic      is_imm;
    logic      is_branch;
    logic      resolves;
    logic      use_a;
    logic      use_b;
    logic      reg_we;
    reg_addr_t dx_dest;
    reg_addr_t xm_dest;
    logic      dx_is_load;
    logic      xm_is_load;
    logic      hit_dx;
    logic      hit_xm;
    word_t     val_a;
    word_t     val_b;
    logic      taken;

    assign op = get_op(fd_instr);
    assign is_rtype = (op == op_rtype);
    assign is_lw = (op == op_lw);
    assign is_sw = (op == op_sw);
    assign is_imm = (op == op_addi) || is_lw || is_sw;
    assign is_branch = (op == op_bne) || (op == op_blt);
    assign resolves = is_branch || (op == op_jr);

    // Port A carries rd for compares and jr, port B carries the store data for sw
    assign rd_addr_a = resolves ? get_rd(fd_instr) : get_rs(fd_instr);
    assign rd_addr_b = is_sw ? get_rd(fd_instr)
                     : (is_branch ? get_rs(fd_instr) : get_rt(fd_instr));

    assign use_a = is_rtype || is_imm || resolves;
    assign use_b = is_rtype || is_sw || is_branch;

    // Writes to r0 are dropped here
    assign reg_we = (is_rtype || (op == op_addi) || is_lw || (op == op_jal))
                    && (dest_reg(fd_instr) != '0);

    assign dx_dest = dest_reg(dx_instr);
    assign xm_dest = dest_reg(xm_instr);
    assign dx_is_load = (dx_wb_src == wb_load);
    assign xm_is_load = (get_op(xm_instr) == op_lw);

    assign hit_dx = dx_reg_we
                    && ((use_a && rd_addr_a == dx_dest) || (use_b && rd_addr_b == dx_dest));
    assign hit_xm = xm_reg_we
                    && ((use_a && rd_addr_a == xm_dest) || (use_b && rd_addr_b == xm_dest));

    // Load-use waits one cycle, compares wait until the writer leaves execute
    // and a load writer also leaves memory
    assign stall = (hit_dx && (dx_is_load || resolves)) || (hit_xm && xm_is_load && resolves);

    assign val_a = (xm_reg_we && !xm_is_load && xm_dest == rd_addr_a) ? xm_result : rd_data_a;
    assign val_b = (xm_reg_we && !xm_is_load && xm_dest == rd_addr_b) ? xm_result : rd_data_b;

    always_comb begin
        taken = 1'b0;
        redirect_pc = get_target(fd_instr);
        case (op)
            op_bne: begin
                taken = (val_a != val_b);
                redirect_pc = fd_pc_next + get_imm(fd_instr);
            end
            op_blt: begin
                // Signed rd < rs
                taken = ($signed(val_a) < $signed(val_b));
                redirect_pc = fd_pc_next + get_imm(fd_instr);
            end
            op_j, op_jal: taken = 1'b1;
            op_jr: begin
                taken = 1'b1;
                redirect_pc = val_a;
            end
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken && !stall;

    // A stall sends a bubble into execute
    always_ff @(posedge clock) begin
        if (reset || stall) begin
            dx_instr <= nop_instr;
            dx_reg_we <= 1'b0;
            dx_mem_we <= 1'b0;
            dx_use_imm <= 1'b0;
            dx_wb_src <= wb_result;
        end else begin
            dx_instr <= fd_instr;
            dx_reg_we <= reg_we;
            dx_mem_we <= is_sw;
            dx_use_imm <= is_imm;
            dx_wb_src <= is_lw ? wb_load : wb_result;
        end
    end

    always_ff @(posedge clock) begin
        dx_pc_next <= fd_pc_next;
        dx_a <= rd_data_a;
        dx_b <= rd_data_b;
    end

endmodule

/* execute_stage.sv */
// Operand forwarding, ALU and the X/M register
`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  instr_t    dx_instr,
    input  word_t     dx_pc_next,
    input  word_t     dx_a,
    input  word_t     dx_b,
    input  logic      dx_reg_we,
    input  logic      dx_mem_we,
    input  logic      dx_use_imm,
    input  wb_src_t   dx_wb_src,
    input  logic      wb_en,
    input  reg_addr_t wb_reg,
    input  word_t     wb_data,
    output instr_t    xm_instr,
    output word_t     xm_result,
    output word_t     xm_store_data,
    output logic      xm_reg_we,
    output logic      xm_mem_we,
    output wb_src_t   xm_wb_src
);

    opcode_t   op;
    reg_addr_t src_b;
    reg_addr_t xm_dest;
    fwd_sel_t  sel_a;
    fwd_sel_t  sel_b;
    word_t     opnd_a;
    word_t     reg_b;
    word_t     opnd_b;
    alu_op_t   alu_op;
    shamt_t    shamt;
    word_t     alu_out;
    logic      reads_a;
    logic      reads_b;

    assign op = get_op(dx_instr);
    // sw keeps its store data register in rd
    assign src_b = dx_mem_we ? get_rd(dx_instr) : get_rt(dx_instr);
    assign xm_dest = dest_reg(xm_instr);

    assign sel_a = fwd_select(get_rs(dx_instr), xm_reg_we, xm_dest, wb_en, wb_reg);
    assign sel_b = fwd_select(src_b, xm_reg_we, xm_dest, wb_en, wb_reg);
    assign opnd_a = fwd_mux(sel_a, dx_a, xm_result, wb_data);
    assign reg_b = fwd_mux(sel_b, dx_b, xm_result, wb_data);
    assign opnd_b = dx_use_imm ? get_imm(dx_instr) : reg_b;

    // addi, lw and sw all add
    assign alu_op = (op == op_rtype) ? get_alu_op(dx_instr) : alu_add;
    assign shamt = get_shamt(dx_instr);

    always_comb begin
        case (alu_op)
            alu_sub: alu_out = opnd_a - opnd_b;
            alu_and: alu_out = opnd_a & opnd_b;
            alu_or:  alu_out = opnd_a | opnd_b;
            alu_sll: alu_out = opnd_a << shamt;
            alu_sra: alu_out = word_t'($signed(opnd_a) >>> shamt);
            default: alu_out = opnd_a + opnd_b;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xm_instr <= nop_instr;
            xm_reg_we <= 1'b0;
            xm_mem_we <= 1'b0;
            xm_wb_src <= wb_result;
        end else begin
            xm_instr <= dx_instr;
            xm_reg_we <= dx_reg_we;
            xm_mem_we <= dx_mem_we;
            xm_wb_src <= dx_wb_src;
        end
    end

    // jal links the address after itself
    always_ff @(posedge clock) begin
        xm_result <= (op == op_jal) ? dx_pc_next : alu_out;
        xm_store_data <= reg_b;
    end

    assign reads_a = (op == op_rtype) || dx_use_imm;
    assign reads_b = (op == op_rtype) || dx_mem_we;

    // The load-use stall in decode keeps load addresses off the X/M forward path
    assert property (@(posedge clock) disable iff (reset)
        !(xm_wb_src == wb_load
          && ((reads_a && sel_a == fwd_mem) || (reads_b && sel_b == fwd_mem))));

endmodule

/* fetch_stage.sv */
// Program counter, post-reset fetch hold, next-PC selection and the F/D register
`timescale 1ns/1ps

module fetch_stage
    import cpu_isa_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  redirect_pc,
    output word_t  imem_addr,
    input  instr_t imem_data,
    output instr_t fd_instr,
    output word_t  fd_pc_next
);

    // Cycles after reset before the first fetch leaves reset_pc
    localparam int hold_cycles = 4;

    word_t      pc;
    word_t      pc_plus_1;
    logic [2:0] hold_count;
    logic       holding;

    assign pc_plus_1 = pc + 32'd1;
    assign holding = (hold_count != 3'd0);
    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= reset_pc;
            hold_count <= 3'(hold_cycles);
            fd_instr <= nop_instr;
        end else if (holding) begin
            // Memories are not yet driven, so only bubbles enter decode
            hold_count <= hold_count - 3'd1;
            fd_instr <= nop_instr;
        end else if (redirect) begin
            // The word fetched next to a taken redirect is squashed
            pc <= redirect_pc;
            fd_instr <= nop_instr;
        end else if (!stall) begin
            pc <= pc_plus_1;
            fd_instr <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_next <= pc_plus_1;
        end
    end

    // Decode only redirects once its operands are ready
    assert property (@(posedge clock) disable iff (reset) !(stall && redirect));

endmodule

/* list.f */
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_writeback.sv
processor.sv
tb_processor.sv

/* memory_writeback.sv */
// Data memory drive, the M/W register and writeback value selection
`timescale 1ns/1ps

module memory_writeback
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  instr_t    xm_instr,
    input  word_t     xm_result,
    input  word_t     xm_store_data,
    input  logic      xm_reg_we,
    input  logic      xm_mem_we,
    input  wb_src_t   xm_wb_src,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_wen,
    input  word_t     dmem_rdata,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    wb_src_t mw_wb_src;
    word_t   mw_result;
    word_t   mw_load_data;

    // Address comes from the ALU sum of base and offset
    assign dmem_addr = xm_result;
    assign dmem_wdata = xm_store_data;
    assign dmem_wen = xm_mem_we;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_en <= 1'b0;
            mw_wb_src <= wb_result;
        end else begin
            wb_en <= xm_reg_we;
            mw_wb_src <= xm_wb_src;
        end
    end

    always_ff @(posedge clock) begin
        wb_reg <= dest_reg(xm_instr);
        mw_result <= xm_result;
        mw_load_data <= dmem_rdata;
    end

    assign wb_data = (mw_wb_src == wb_load) ? mw_load_data : mw_result;

    // Decode marks a word as either a store or a load, never both
    assert property (@(posedge clock) disable iff (reset) !(dmem_wen && xm_wb_src == wb_load));

endmodule

/* processor.sv */
// Processor top level connecting the five pipeline stages and the register file
`timescale 1ns/1ps

module processor
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
#(
    parameter word_t reset_pc = '0
) (
    input  logic      clock,
    input  logic      reset,
    output word_t     imem_addr,
    input  instr_t    imem_data,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_wen,
    input  word_t     dmem_rdata,
    output logic      wb_en,
    output reg_addr_t wb_reg,
    output word_t     wb_data
);

    // Fetch to decode
    instr_t    fd_instr;
    word_t     fd_pc_next;
    logic      stall;
    logic      redirect;
    word_t     redirect_pc;

    // Register file read ports
    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;

    // Decode/execute register
    instr_t    dx_instr;
    word_t     dx_pc_next;
    word_t     dx_a;
    word_t     dx_b;
    logic      dx_reg_we;
    logic      dx_mem_we;
    logic      dx_use_imm;
    wb_src_t   dx_wb_src;

    // Execute/memory register
    instr_t    xm_instr;
    word_t     xm_result;
    word_t     xm_store_data;
    logic      xm_reg_we;
    logic      xm_mem_we;
    wb_src_t   xm_wb_src;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) fetch_stage_inst (
        .clock, .reset, .stall, .redirect, .redirect_pc,
        .imem_addr, .imem_data, .fd_instr, .fd_pc_next
    );

    decode_stage decode_stage_inst (
        .clock, .reset, .fd_instr, .fd_pc_next,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .xm_instr, .xm_result, .xm_reg_we,
        .stall, .redirect, .redirect_pc,
        .dx_instr, .dx_pc_next, .dx_a, .dx_b,
        .dx_reg_we, .dx_mem_we, .dx_use_imm, .dx_wb_src
    );

    register_file register_file_inst (
        .clock, .reset,
        .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
        .wr_en(wb_en), .wr_addr(wb_reg), .wr_data(wb_data)
    );

    execute_stage execute_stage_inst (
        .clock, .reset,
        .dx_instr, .dx_pc_next, .dx_a, .dx_b,
        .dx_reg_we, .dx_mem_we, .dx_use_imm, .dx_wb_src,
        .wb_en, .wb_reg, .wb_data,
        .xm_instr, .xm_result, .xm_store_data, .xm_reg_we, .xm_mem_we, .xm_wb_src
    );

    memory_writeback memory_writeback_inst (
        .clock, .reset,
        .xm_instr, .xm_result, .xm_store_data, .xm_reg_we, .xm_mem_we, .xm_wb_src,
        .dmem_addr, .dmem_wdata, .dmem_wen, .dmem_rdata,
        .wb_en, .wb_reg, .wb_data
    );

endmodule

/* register_file.sv */
// Register file with 32 words, two write-through read ports and one write port
`timescale 1ns/1ps

module register_file
    import cpu_isa_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [32];

    function automatic word_t read_port(reg_addr_t addr);
        // r0 is hardwired to zero
        if (addr == '0) begin
            return '0;
        end
        // Writeback in the same cycle is seen by decode
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* tb_isa_model.svh */
// Random program generator, instruction encoders, data memory fill and instruction-level model
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int prog_len = 48;
localparam int last_pc = prog_len - 1;
localparam int dmem_depth = 32;

instr_t    prog [prog_len];
opcode_t   kind [prog_len];

// Expected writeback and store streams in program order
reg_addr_t exp_wb_reg [$];
word_t     exp_wb_data [$];
word_t     exp_st_addr [$];
word_t     exp_st_data [$];

function automatic word_t fill_word(int addr);
    return 32'h3c5a_0000 ^ (word_t'(addr) * 32'h0001_9e37) ^ (word_t'(addr) << 27);
endfunction

function automatic instr_t rtype_word(int alu, int rd, int rs, int rt, int shamt);
    return {5'(op_rtype), 5'(rd), 5'(rs), 5'(rt), 5'(shamt), 5'(alu), 2'b00};
endfunction

function automatic instr_t imm_word(opcode_t op, int rd, int rs, logic [16:0] imm);
    return {5'(op), 5'(rd), 5'(rs), imm};
endfunction

function automatic instr_t jump_word(opcode_t op, int target);
    return {5'(op), 27'(target)};
endfunction

// Forward by 0 to 3 past the next word, never onto a jr whose addi would be skipped
function automatic int forward_target(int p);
    int t;
    t = p + 1 + int'($urandom_range(3));
    if (t > last_pc) begin
        t = last_pc;
    end
    while (kind[t] == op_jr) begin
        t--;
    end
    return t;
endfunction

task automatic gen_program();
    int p;
    int pick;
    int t;
    int rd;
    int rs;
    int rt;
    word_t v;
    // First pass lays out the opcodes, an addi/jr pair takes two slots
    p = 0;
    while (p < last_pc) begin
        pick = $urandom_range(15);
        if (pick == 15 && p + 1 < last_pc) begin
            kind[p] = op_addi;
            kind[p + 1] = op_jr;
            p = p + 2;
        end else begin
            case (pick)
                0, 1, 2, 3, 4: kind[p] = op_rtype;
                5, 6:          kind[p] = op_addi;
                7, 8:          kind[p] = op_lw;
                9, 10:         kind[p] = op_sw;
                11:            kind[p] = op_bne;
                12:            kind[p] = op_blt;
                13:            kind[p] = op_j;
                default:       kind[p] = op_jal;
            endcase
            p = p + 1;
        end
    end
    kind[last_pc] = op_j;

    // Second pass fills in registers, immediates and targets
    for (p = 0; p < prog_len; p++) begin
        rd = $urandom_range(7);
        rs = $urandom_range(7);
        rt = $urandom_range(7);
        v = $urandom;
        case (kind[p])
            op_rtype: prog[p] = rtype_word(int'(v % 6), rd, rs, rt, int'(v[12:8]));
            op_addi: begin
                if (kind[p + 1] == op_jr) begin
                    if (rd == 0) begin
                        rd = 7;
                    end
                    t = forward_target(p + 1);
                    prog[p] = imm_word(op_addi, rd, 0, 17'(t));
                    prog[p + 1] = imm_word(op_jr, rd, 0, '0);
                end else begin
                    prog[p] = imm_word(op_addi, rd, rs, v[16:0]);
                end
            end
            op_lw, op_sw: prog[p] = imm_word(kind[p], rd, 0, 17'(v % 16));
            op_bne, op_blt: begin
                t = forward_target(p);
                prog[p] = imm_word(kind[p], rd, rs, 17'(t - p - 1));
            end
            op_j, op_jal: begin
                t = (p == last_pc) ? last_pc : forward_target(p);
                prog[p] = jump_word(kind[p], t);
            end
            default: begin
                // jr was written together with its addi
            end
        endcase
    end
endtask

task automatic run_model();
    word_t  regs [32];
    word_t  mem [dmem_depth];
    instr_t ins;
    word_t  imm;
    word_t  res;
    word_t  addr;
    int     pc;
    int     next;
    int     steps;
    int     i;
    logic   wr;
    int     wr_reg;
    for (i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (i = 0; i < dmem_depth; i++) begin
        mem[i] = fill_word(i);
    end
    pc = 0;
    steps = 0;
    while (pc != last_pc && steps < 4 * prog_len) begin
        ins = prog[pc];
        imm = {{15{ins[16]}}, ins[16:0]};
        next = pc + 1;
        wr = 1'b0;
        wr_reg = ins[26:22];
        res = '0;
        case (ins[31:27])
            op_rtype: begin
                wr = 1'b1;
                case (ins[6:2])
                    alu_sub: res = regs[ins[21:17]] - regs[ins[16:12]];
                    alu_and: res = regs[ins[21:17]] & regs[ins[16:12]];
                    alu_or:  res = regs[ins[21:17]] | regs[ins[16:12]];
                    alu_sll: res = regs[ins[21:17]] << ins[11:7];
                    alu_sra: res = word_t'($signed(regs[ins[21:17]]) >>> ins[11:7]);
                    default: res = regs[ins[21:17]] + regs[ins[16:12]];
                endcase
            end
            op_addi: begin
                wr = 1'b1;
                res = regs[ins[21:17]] + imm;
            end
            op_lw: begin
                wr = 1'b1;
                addr = regs[ins[21:17]] + imm;
                res = mem[addr % dmem_depth];
            end
            op_sw: begin
                addr = regs[ins[21:17]] + imm;
                mem[addr % dmem_depth] = regs[ins[26:22]];
                exp_st_addr.push_back(addr);
                exp_st_data.push_back(regs[ins[26:22]]);
            end
            op_bne: begin
                if (regs[ins[26:22]] != regs[ins[21:17]]) begin
                    next = pc + 1 + $signed(imm);
                end
            end
            op_blt: begin
                if ($signed(regs[ins[26:22]]) < $signed(regs[ins[21:17]])) begin
                    next = pc + 1 + $signed(imm);
                end
            end
            op_j: next = ins[26:0];
            op_jal: begin
                wr = 1'b1;
                wr_reg = 31;
                res = pc + 1;
                next = ins[26:0];
            end
            op_jr: next = regs[ins[26:22]];
            default: next = pc + 1;
        endcase
        // r0 stays zero and never shows up on the writeback port
        if (wr && wr_reg != 0) begin
            regs[wr_reg] = res;
            exp_wb_reg.push_back(5'(wr_reg));
            exp_wb_data.push_back(res);
        end
        pc = next;
        steps++;
    end
endtask

`endif

/* tb_processor.sv */
// Testbench with clock, reset, memory models, writeback and store checkers and the final report
`timescale 1ns/1ps

module tb_processor
    import cpu_isa_pkg::*;
();

    localparam int          imem_depth = 64;
    localparam int          reset_cycles = 5;
    localparam int          quiet_after_reset = 4;
    localparam int          run_timeout = 2000;
    localparam int          settle_timeout = 20;
    localparam int          quiet_cycles = 10;
    localparam int unsigned rand_seed = 32'h4a1da75d;
    localparam word_t       start_pc = 32'd0;

    `include "tb_isa_model.svh"

    logic      clock = 1'b0;
    logic      reset;
    word_t     imem_addr;
    instr_t    imem_data;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_wen;
    word_t     dmem_rdata;
    logic      wb_en;
    reg_addr_t wb_reg;
    word_t     wb_data;

    instr_t inst_mem [imem_depth];
    word_t  data_mem [dmem_depth];

    int reset_errors = 0;
    int wb_errors = 0;
    int store_errors = 0;
    int other_errors = 0;
    int wb_seen = 0;
    int st_seen = 0;

    processor #(
        .reset_pc(start_pc)
    ) processor_inst (
        .clock(clock),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_wen(dmem_wen),
        .dmem_rdata(dmem_rdata),
        .wb_en(wb_en),
        .wb_reg(wb_reg),
        .wb_data(wb_data)
    );

    initial begin
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic load_memories();
        int i;
        for (i = 0; i < imem_depth; i++) begin
            inst_mem[i] = (i < prog_len) ? prog[i] : nop_instr;
        end
        for (i = 0; i < dmem_depth; i++) begin
            data_mem[i] = fill_word(i);
        end
    endtask

    task automatic check_writeback();
        reg_addr_t r;
        word_t     d;
        if (wb_reg == '0) begin
            other_errors++;
            $display("writeback names r0 with data %h", wb_data);
        end
        if (exp_wb_reg.size() == 0) begin
            other_errors++;
            $display("writeback to r%0d with data %h after the expected stream ended",
                     wb_reg, wb_data);
        end else begin
            r = exp_wb_reg.pop_front();
            d = exp_wb_data.pop_front();
            if (wb_reg !== r || wb_data !== d) begin
                wb_errors++;
                $display("error writeback %0d: expected r%0d = %h, actual r%0d = %h",
                         wb_seen, r, d, wb_reg, wb_data);
            end
            wb_seen++;
        end
    endtask

    task automatic check_store();
        word_t a;
        word_t d;
        if (exp_st_addr.size() == 0) begin
            other_errors++;
            $display("store to address %0h with data %h after the expected stream ended",
                     dmem_addr, dmem_wdata);
        end else begin
            a = exp_st_addr.pop_front();
            d = exp_st_data.pop_front();
            if (dmem_addr !== a || dmem_wdata !== d) begin
                store_errors++;
                $display("error store %0d: expected [%0h] = %h, actual [%0h] = %h",
                         st_seen, a, d, dmem_addr, dmem_wdata);
            end
            st_seen++;
        end
    endtask

    // Memories answer on the falling edge for the addresses set at the rising edge
    always @(negedge clock) begin
        if (dmem_wen === 1'b1) begin
            check_store();
            data_mem[dmem_addr % dmem_depth] = dmem_wdata;
        end
        if (wb_en === 1'b1) begin
            check_writeback();
        end
        imem_data <= (imem_addr < imem_depth) ? inst_mem[imem_addr] : nop_instr;
        dmem_rdata <= data_mem[dmem_addr % dmem_depth];
    end

    task automatic check_idle(input int cycle);
        if (wb_en !== 1'b0 || dmem_wen !== 1'b0 || imem_addr !== start_pc) begin
            reset_errors++;
            $display("error reset %0d: expected wb_en 0 dmem_wen 0 pc %0h, actual %b %b %0h",
                     cycle, start_pc, wb_en, dmem_wen, imem_addr);
        end
    endtask

    initial begin
        int   cycle;
        logic settled;
        reset = 1'b1;
        imem_data = nop_instr;
        dmem_rdata = '0;
        void'($urandom(rand_seed));
        gen_program();
        run_model();
        load_memories();

        // Reset phase plus the fetch hold that follows it
        for (cycle = 0; cycle < reset_cycles + quiet_after_reset; cycle++) begin
            @(negedge clock);
            check_idle(cycle);
            if (cycle == reset_cycles - 1) begin
                reset = 1'b0;
            end
        end

        cycle = 0;
        while ((exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) && cycle < run_timeout) begin
            @(posedge clock);
            cycle++;
        end

        if (exp_wb_reg.size() != 0 || exp_st_addr.size() != 0) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d writebacks and %0d stores still expected",
                     run_timeout, exp_wb_reg.size(), exp_st_addr.size());
        end else begin
            settled = 1'b0;
            for (cycle = 0; cycle < settle_timeout && !settled; cycle++) begin
                @(negedge clock);
                settled = (imem_addr == word_t'(last_pc));
            end
            if (!settled) begin
                other_errors++;
                $display("fetch never reached the final self-jump at %0d", last_pc);
            end else begin
                // The self-jump alternates between its own word and the squashed one after it
                for (cycle = 0; cycle < quiet_cycles; cycle++) begin
                    @(negedge clock);
                    if (imem_addr != word_t'(last_pc) && imem_addr != word_t'(last_pc + 1)) begin
                        other_errors++;
                        $display("error settle: expected imem_addr %0d or %0d, actual %0d",
                                 last_pc, last_pc + 1, imem_addr);
                    end
                end
            end
        end

        $display("errors: reset %0d, writeback %0d, store %0d, other %0d",
                 reset_errors, wb_errors, store_errors, other_errors);
        if (reset_errors + wb_errors + store_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
